// File: logic/serpentPkg.sv
package serpentPkg;

	localparam int ROUNDS = 32;
	localparam logic [31:0] PHI = 32'h9e3779b9;

	// Word addresses on the bus.
	localparam logic [4:0] ADR_KEY0 = 5'd0;
	localparam logic [4:0] ADR_PLAIN0 = 5'd8;
	localparam logic [4:0] ADR_CTRL = 5'd12;
	localparam logic [4:0] ADR_STATUS = 5'd13;
	localparam logic [4:0] ADR_CIPHER0 = 5'd16;

	// Bitslice block; the nibble of column j is {w3[j], w2[j], w1[j], w0[j]}.
	typedef struct packed
	{
		logic [31:0] w3;
		logic [31:0] w2;
		logic [31:0] w1;
		logic [31:0] w0;
	} blockT;

	typedef logic [7:0][31:0] keyT;

	typedef struct packed
	{
		logic [4:0] adr;
		logic we;
		logic [31:0] dat;
	} wbReqT;

	typedef struct packed
	{
		keyT key;
		blockT plain;
		logic start;
	} cipherReqT;

	typedef struct packed
	{
		blockT cipher;
		logic valid;
	} cipherRespT;

	function automatic logic [31:0] rotl(input logic [31:0] value, input int amount);
		return (value << amount) | (value >> (32 - amount));
	endfunction

endpackage

// File: logic/sBox.sv
module sBox
(
	input logic [2:0] sel,
	input serpentPkg::blockT inData,
	output serpentPkg::blockT outData
);

	// Each table is packed with entry 0 in the lowest nibble.
	function automatic logic [3:0] substitute(input logic [2:0] box, input logic [3:0] nibble);
		logic [63:0] entries;
		case (box)
			3'd0:
				entries = 64'hc907_24de_b56a_1f83;
			3'd1:
				entries = 64'h43d6_8eb1_a509_72cf;
			3'd2:
				entries = 64'h25b0_4e1d_fac3_9768;
			3'd3:
				entries = 64'he57a_421d_369c_8bf0;
			3'd4:
				entries = 64'hd7e9_a452_6b0c_38f1;
			3'd5:
				entries = 64'h176d_8e30_c9a4_b25f;
			3'd6:
				entries = 64'h0a3d_f19e_b648_5c27;
			default:
				entries = 64'h6539_ac47_b28e_0fd1;
		endcase
		return entries[{nibble, 2'b00} +: 4];
	endfunction

	always_comb
	begin
		logic [3:0] column;
		for (int j = 0; j < 32; j++)
		begin
			column = substitute(sel, {inData.w3[j], inData.w2[j], inData.w1[j], inData.w0[j]});
			outData.w3[j] = column[3];
			outData.w2[j] = column[2];
			outData.w1[j] = column[1];
			outData.w0[j] = column[0];
		end
	end

endmodule

// File: logic/linearTransform.sv
module linearTransform
(
	input serpentPkg::blockT inData,
	output serpentPkg::blockT outData
);

	logic [31:0] x0;
	logic [31:0] x1;
	logic [31:0] x2;
	logic [31:0] x3;

	always_comb
	begin
		x0 = serpentPkg::rotl(inData.w0, 13);
		x2 = serpentPkg::rotl(inData.w2, 3);
		x1 = inData.w1 ^ x0 ^ x2;
		x3 = inData.w3 ^ x2 ^ (x0 << 3);
		x1 = serpentPkg::rotl(x1, 1);
		x3 = serpentPkg::rotl(x3, 7);
		x0 = x0 ^ x1 ^ x3;
		x2 = x2 ^ x3 ^ (x1 << 7);
		x0 = serpentPkg::rotl(x0, 5);
		x2 = serpentPkg::rotl(x2, 22);
	end

	assign outData = '{w3: x3, w2: x2, w1: x1, w0: x0};

endmodule

// File: logic/keyExpand.sv
module keyExpand
(
	input logic clk,
	input logic rstN,
	input logic load,
	input serpentPkg::keyT key,
	input logic advance,
	output serpentPkg::blockT subkey
);

	// Window entry 0 is the oldest prekey, entry 7 the newest.
	serpentPkg::keyT window;
	logic [5:0] index;
	logic [11:0][31:0] chain;
	logic [2:0] sel;
	serpentPkg::blockT fresh;

	// Prekey i = 4 * index + j, built on the words just produced before it.
	always_comb
	begin
		chain[7:0] = window;
		for (int j = 0; j < 4; j++)
			chain[8 + j] = serpentPkg::rotl(chain[j] ^ chain[j + 3] ^ chain[j + 5]
				^ chain[j + 7] ^ serpentPkg::PHI ^ (32'(index) * 32'd4 + 32'(j)), 11);
	end

	assign fresh = chain[11:8];
	assign sel = 3'd3 - index[2:0];

	sBox uSbox
	(
		.sel(sel),
		.inData(fresh),
		.outData(subkey)
	);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			index <= '0;
		else if (load)
			index <= '0;
		else if (advance)
			index <= index + 6'd1;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			window <= key;
		else if (advance)
			window <= chain[11:4];
	end

	// The engine stops advancing once subkey 32 is on show.
	indexBound: assert property (@(posedge clk) disable iff (!rstN)
		index <= 6'(serpentPkg::ROUNDS))
		else $error("key schedule stepped past the last subkey");

endmodule

// File: logic/roundEngine.sv
module roundEngine
(
	input logic clk,
	input logic rstN,
	input serpentPkg::cipherReqT req,
	output logic busy,
	output serpentPkg::cipherRespT resp
);

	logic [5:0] round;
	logic accept;
	logic advance;
	serpentPkg::blockT state;
	serpentPkg::blockT subkey;
	serpentPkg::blockT keyed;
	serpentPkg::blockT subbed;
	serpentPkg::blockT mixed;

	assign accept = req.start && !busy;
	assign advance = busy && round < 6'(serpentPkg::ROUNDS);

	keyExpand uKey
	(
		.clk(clk),
		.rstN(rstN),
		.load(accept),
		.key(req.key),
		.advance(advance),
		.subkey(subkey)
	);

	assign keyed = state ^ subkey;

	sBox uSbox
	(
		.sel(round[2:0]),
		.inData(keyed),
		.outData(subbed)
	);

	linearTransform uMix
	(
		.inData(subbed),
		.outData(mixed)
	);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			round <= '0;
		end
		else if (accept)
		begin
			busy <= 1'b1;
			round <= '0;
		end
		else if (busy)
		begin
			if (round == 6'(serpentPkg::ROUNDS))
				busy <= 1'b0;
			else
				round <= round + 6'd1;
		end
	end

	// Round 31 skips the mixing; the final key XOR happens on the output.
	always_ff @(posedge clk)
	begin
		if (accept)
			state <= req.plain;
		else if (busy && round < 6'(serpentPkg::ROUNDS - 1))
			state <= mixed;
		else if (busy && round == 6'(serpentPkg::ROUNDS - 1))
			state <= subbed;
	end

	assign resp.cipher = keyed;
	assign resp.valid = busy && round == 6'(serpentPkg::ROUNDS);

	validInRun: assert property (@(posedge clk) disable iff (!rstN)
		resp.valid |-> $past(busy))
		else $error("result valid outside a run");

	// A second start must not restart the round counter.
	busyStartIgnored: assert property (@(posedge clk) disable iff (!rstN)
		req.start && busy |=> round != 6'd0)
		else $error("start during a run restarted the engine");

endmodule

// File: logic/wbRegDecode.sv
module wbRegDecode
(
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [4:0] adr,
	input logic [31:0] datI,
	output logic [31:0] datO,
	output logic ack,
	output serpentPkg::cipherReqT req,
	output logic [4:0] rdAdr,
	input logic [31:0] rdData
);

	serpentPkg::wbReqT access;
	serpentPkg::keyT keyReg;
	logic [3:0][31:0] plainReg;
	logic sample;
	logic writeKey;
	logic writePlain;

	assign sample = cyc && stb && !ack;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			ack <= 1'b0;
		else
			ack <= sample;
	end

	// The access is held through its ack cycle and acted on there.
	always_ff @(posedge clk)
	begin
		if (sample)
			access <= '{adr: adr, we: we, dat: datI};
	end

	assign writeKey = ack && access.we && access.adr[4:3] == serpentPkg::ADR_KEY0[4:3];
	assign writePlain = ack && access.we && access.adr[4:2] == serpentPkg::ADR_PLAIN0[4:2];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			keyReg <= '0;
			plainReg <= '0;
		end
		else if (writeKey)
			keyReg[access.adr[2:0]] <= access.dat;
		else if (writePlain)
			plainReg[access.adr[1:0]] <= access.dat;
	end

	assign req.key = keyReg;
	assign req.plain = plainReg;
	assign req.start = ack && access.we && access.adr == serpentPkg::ADR_CTRL && access.dat[0];

	assign rdAdr = access.adr;
	assign datO = (ack && !access.we) ? rdData : 32'd0;

	ackOneCycle: assert property (@(posedge clk) disable iff (!rstN)
		ack |=> !ack)
		else $error("ack held for two cycles");

endmodule

// File: logic/resultRegs.sv
module resultRegs
(
	input logic clk,
	input logic rstN,
	input serpentPkg::cipherRespT resp,
	input logic startSeen,
	input logic busy,
	input logic [4:0] rdAdr,
	output logic [31:0] rdData
);

	logic [3:0][31:0] cipherReg;
	logic done;

	// Done only drops on a start the engine will actually take.
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cipherReg <= '0;
			done <= 1'b0;
		end
		else if (resp.valid)
		begin
			cipherReg <= resp.cipher;
			done <= 1'b1;
		end
		else if (startSeen && !busy)
			done <= 1'b0;
	end

	always_comb
	begin
		rdData = 32'd0;
		if (rdAdr == serpentPkg::ADR_STATUS)
			rdData = {30'd0, done, busy};
		else if (rdAdr[4:2] == serpentPkg::ADR_CIPHER0[4:2])
			rdData = cipherReg[rdAdr[1:0]];
	end

endmodule

// File: logic/serpentCore.sv
module serpentCore
(
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [4:0] adr,
	input logic [31:0] datI,
	output logic [31:0] datO,
	output logic ack
);

	serpentPkg::cipherReqT req;
	serpentPkg::cipherRespT resp;
	logic busy;
	logic [4:0] rdAdr;
	logic [31:0] rdData;

	wbRegDecode uDecode
	(
		.clk(clk),
		.rstN(rstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datI(datI),
		.datO(datO),
		.ack(ack),
		.req(req),
		.rdAdr(rdAdr),
		.rdData(rdData)
	);

	roundEngine uEngine
	(
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.busy(busy),
		.resp(resp)
	);

	resultRegs uResult
	(
		.clk(clk),
		.rstN(rstN),
		.resp(resp),
		.startSeen(req.start),
		.busy(busy),
		.rdAdr(rdAdr),
		.rdData(rdData)
	);

endmodule

// File: sim/serpentModel.svh
`ifndef SERPENT_MODEL_SVH
`define SERPENT_MODEL_SVH

// Reference Serpent encryption on the bitslice form, without the IP and FP permutations.

function automatic logic [31:0] modelRotl(input logic [31:0] x, input int n);
	logic [63:0] twice;
	twice = {x, x};
	return twice[63 - n -: 32];
endfunction

// Tables are written in reading order, entry 0 in the top nibble.
function automatic serpentPkg::blockT modelSubstitute(input int box, input serpentPkg::blockT x);
	logic [0:7][63:0] tables;
	serpentPkg::blockT y;
	int nib;
	logic [3:0] sub;
	tables = {
		64'h38f1_a65b_ed42_709c,
		64'hfc27_905a_1be8_6d34,
		64'h8679_3caf_d1e4_0b52,
		64'h0fb8_c963_d124_a75e,
		64'h1f83_c0b6_254a_9e7d,
		64'hf52b_4a9c_03e8_d671,
		64'h72c5_846b_e91f_d3a0,
		64'h1df0_e82b_74ca_9356};
	for (int j = 0; j < 32; j++)
	begin
		nib = {x.w3[j], x.w2[j], x.w1[j], x.w0[j]};
		sub = tables[box][63 - 4 * nib -: 4];
		y.w3[j] = sub[3];
		y.w2[j] = sub[2];
		y.w1[j] = sub[1];
		y.w0[j] = sub[0];
	end
	return y;
endfunction

function automatic serpentPkg::blockT modelMix(input serpentPkg::blockT x);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	logic [31:0] d;
	a = modelRotl(x.w0, 13);
	c = modelRotl(x.w2, 3);
	b = modelRotl(x.w1 ^ a ^ c, 1);
	d = modelRotl(x.w3 ^ c ^ (a << 3), 7);
	a = modelRotl(a ^ b ^ d, 5);
	c = modelRotl(c ^ d ^ (b << 7), 22);
	return {d, c, b, a};
endfunction

function automatic serpentPkg::blockT modelEncrypt(input serpentPkg::keyT key,
	input serpentPkg::blockT plain);
	logic [31:0] w [0:139];
	serpentPkg::blockT subkeys [0:32];
	serpentPkg::blockT s;
	// Storage index k holds prekey k - 8, so the key words come first.
	for (int i = 0; i < 8; i++)
		w[i] = key[i];
	for (int i = 0; i < 132; i++)
		w[i + 8] = modelRotl(w[i] ^ w[i + 3] ^ w[i + 5] ^ w[i + 7] ^ serpentPkg::PHI ^ 32'(i), 11);
	for (int k = 0; k < 33; k++)
		subkeys[k] = modelSubstitute((35 - k) % 8, {w[4 * k + 11], w[4 * k + 10],
			w[4 * k + 9], w[4 * k + 8]});
	s = plain;
	for (int r = 0; r < 32; r++)
	begin
		s = modelSubstitute(r % 8, s ^ subkeys[r]);
		if (r < 31)
			s = modelMix(s);
		else
			s = s ^ subkeys[32];
	end
	return s;
endfunction

`endif

// File: sim/serpentTb.sv
module serpentTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int ENCRYPTIONS = 24;
	localparam int CYCLES_PER_RUN = 200;

	logic clk;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	logic [4:0] adr;
	logic [31:0] datI;
	logic [31:0] datO;
	logic ack;
	int cycles = 0;
	int blockErrors = 0;
	int wordErrors = 0;
	int protocolErrors = 0;
	serpentPkg::keyT lastKey;

	`include "serpentModel.svh"

	serpentCore i_serpentCore (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	initial
	begin
		#(ENCRYPTIONS * CYCLES_PER_RUN * CLK_PERIOD);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

	task automatic compareBlock(input string name, input serpentPkg::blockT expected,
		input serpentPkg::blockT actual);
		if (actual !== expected)
		begin
			blockErrors++;
			$display("Error %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic compareWord(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			wordErrors++;
			$display("Error %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Called 1 ns after an edge; returns 1 ns into the ack cycle with the bus released.
	task automatic busCycle(input logic write, input logic [4:0] address,
		input logic [31:0] data, output logic [31:0] readData);
		int waited;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = address;
		datI = data;
		waited = 0;
		do
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
		end
		while (!ack && waited < 10);
		readData = datO;
		if (!ack)
		begin
			protocolErrors++;
			$display("No ack within 10 cycles for the access to address %0d", address);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbWrite(input logic [4:0] address, input logic [31:0] data);
		logic [31:0] unused;
		busCycle(1'b1, address, data, unused);
	endtask

	task automatic wbRead(input logic [4:0] address, output logic [31:0] data);
		busCycle(1'b0, address, 32'd0, data);
	endtask

	task automatic loadKey(input serpentPkg::keyT key);
		for (int i = 0; i < 8; i++)
			wbWrite(serpentPkg::ADR_KEY0 + 5'(i), key[i]);
		lastKey = key;
	endtask

	task automatic loadPlain(input serpentPkg::blockT plain);
		logic [3:0][31:0] words;
		words = plain;
		for (int i = 0; i < 4; i++)
			wbWrite(serpentPkg::ADR_PLAIN0 + 5'(i), words[i]);
	endtask

	task automatic waitDone;
		logic [31:0] status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[1] && polls < 60)
		begin
			wbRead(serpentPkg::ADR_STATUS, status);
			polls++;
		end
		if (!status[1])
		begin
			protocolErrors++;
			$display("The done flag never came up after a start");
		end
	endtask

	task automatic readCipher(output serpentPkg::blockT cipher);
		logic [3:0][31:0] words;
		for (int i = 0; i < 4; i++)
			wbRead(serpentPkg::ADR_CIPHER0 + 5'(i), words[i]);
		cipher = words;
	endtask

	task automatic runAndCheck(input serpentPkg::keyT key, input serpentPkg::blockT plain);
		serpentPkg::blockT got;
		loadKey(key);
		loadPlain(plain);
		wbWrite(serpentPkg::ADR_CTRL, 32'h1);
		waitDone();
		readCipher(got);
		compareBlock("cipher", modelEncrypt(key, plain), got);
	endtask

	function automatic serpentPkg::keyT randomKey();
		serpentPkg::keyT key;
		for (int i = 0; i < 8; i++)
			key[i] = $urandom;
		return key;
	endfunction

	function automatic serpentPkg::blockT randomBlock();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic checkAfterReset;
		logic [31:0] value;
		wbRead(serpentPkg::ADR_STATUS, value);
		compareWord("status", 32'h0, value);
		for (int i = 0; i < 4; i++)
		begin
			wbRead(serpentPkg::ADR_CIPHER0 + 5'(i), value);
			compareWord("cipher word", 32'h0, value);
		end
	endtask

	task automatic checkStatusTiming;
		serpentPkg::keyT key;
		serpentPkg::blockT plain;
		serpentPkg::blockT got;
		logic [31:0] value;
		int startCycle;
		key = randomKey();
		plain = randomBlock();
		loadKey(key);
		loadPlain(plain);
		wbWrite(serpentPkg::ADR_CTRL, 32'h1);
		startCycle = cycles;
		wbRead(serpentPkg::ADR_STATUS, value);
		compareWord("status while busy", 32'h1, value);
		// The read below is sampled on the 33rd edge after the start edge.
		while (cycles < startCycle + 33)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		wbRead(serpentPkg::ADR_STATUS, value);
		compareWord("status when done", 32'h2, value);
		readCipher(got);
		compareBlock("cipher", modelEncrypt(key, plain), got);
	endtask

	task automatic checkStartWhileBusy;
		serpentPkg::keyT key;
		serpentPkg::blockT first;
		serpentPkg::blockT second;
		serpentPkg::blockT got;
		logic [31:0] value;
		key = randomKey();
		first = randomBlock();
		second = randomBlock();
		loadKey(key);
		loadPlain(first);
		wbWrite(serpentPkg::ADR_CTRL, 32'h1);
		loadPlain(second);
		wbWrite(serpentPkg::ADR_CTRL, 32'h1);
		waitDone();
		readCipher(got);
		compareBlock("cipher with ignored start", modelEncrypt(key, first), got);
		wbWrite(serpentPkg::ADR_CTRL, 32'h1);
		wbRead(serpentPkg::ADR_STATUS, value);
		compareWord("status after restart", 32'h1, value);
		waitDone();
		readCipher(got);
		compareBlock("cipher after restart", modelEncrypt(key, second), got);
	endtask

	task automatic checkKeyRetention;
		serpentPkg::blockT plain;
		serpentPkg::blockT got;
		plain = randomBlock();
		loadPlain(plain);
		wbWrite(serpentPkg::ADR_CTRL, 32'h1);
		waitDone();
		readCipher(got);
		compareBlock("cipher with kept key", modelEncrypt(lastKey, plain), got);
	endtask

	initial
	begin
		void'($urandom(32'h2ecc));
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datI = '0;
		repeat (8) @(posedge clk);
		#DRIVE_DELAY;
		rstN = 1'b1;
		checkAfterReset();
		runAndCheck('0, '0);
		repeat (20)
			runAndCheck(randomKey(), randomBlock());
		checkStatusTiming();
		checkStartWhileBusy();
		checkKeyRetention();
		$display("Errors: %0d block, %0d word, %0d protocol", blockErrors, wordErrors,
			protocolErrors);
		if (blockErrors + wordErrors + protocolErrors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+sim
logic/serpentPkg.sv
logic/sBox.sv
logic/linearTransform.sv
logic/keyExpand.sv
logic/roundEngine.sv
logic/wbRegDecode.sv
logic/resultRegs.sv
logic/serpentCore.sv
sim/serpentTb.sv
